//--- Makefile
# Verilator flow for the Booth multiplier
# any variable can be set on the command line, e.g. make sim JOBS=8

VERILATOR ?= verilator
TOP       ?= booth_mul_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= test passed
VFLAGS    ?= --assert --timing
JOBS      ?= 4

.PHONY: all lint build sim clean

all: sim

# static checks only, no executable
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -j $(JOBS)

# the log decides, so a run stopped by an assertion also fails
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/booth_mul_sva.sv
`timescale 1ns/10ps
`default_nettype none

`include "booth_config.svh"

module booth_mul_sva
(
    input logic                             clk,
    input logic                             arst_n,
    input logic                             load,
    input logic                             done,
    input logic signed [2*`BOOTH_WIDTH-1:0] product
);

    localparam int width = `BOOTH_WIDTH;

    logic [7:0] since_load; // edges since the load edge, stops at width
    logic       armed;      // a load has been seen

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            since_load <= '0;
            armed      <= 1'b0;
        end
        else if (load)
        begin
            since_load <= '0;       // a new load restarts the count
            armed      <= 1'b1;
        end
        else if (since_load < 8'(width))
        begin
            since_load <= since_load + 8'd1;
        end
    end

    //////////////////////////////
    // done timing
    //////////////////////////////

    done_low_after_load: assert property (@(posedge clk) disable iff (!arst_n)
        load |=> !done)
        else $error("done high in the cycle after a load");

    // high exactly from width edges after the last load on
    done_after_steps: assert property (@(posedge clk) disable iff (!arst_n)
        done == (armed && since_load == 8'(width)))
        else $error("done does not follow the step count since the last load");

    //////////////////////////////
    // result hold
    //////////////////////////////

    product_held: assert property (@(posedge clk) disable iff (!arst_n)
        done && !load |=> $stable(product))
        else $error("product moved while done was high");

endmodule

bind booth_mul_top booth_mul_sva u_sva
(
    .clk     (clk),
    .arst_n  (arst_n),
    .load    (load),
    .done    (done),
    .product (product)
);

`default_nettype wire

//--- bench/booth_mul_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "booth_config.svh"

module booth_mul_tb;

    localparam int width      = `BOOTH_WIDTH;
    localparam int pw         = 2 * width;
    localparam int n_directed = 10;
    localparam int n_random   = 16;
    localparam int n_entries  = n_directed + n_random;
    localparam int max_cycles = (n_entries + 2) * (width + 4) + 20; // table, hold and restart

    typedef logic signed [width-1:0] operand_t;
    typedef logic signed [pw-1:0]    product_t;

    localparam operand_t op_zero = '0;
    localparam operand_t op_one  = operand_t'(1);
    localparam operand_t op_neg1 = '1;
    localparam operand_t op_max  = {1'b0, {(width-1){1'b1}}};
    localparam operand_t op_min  = {1'b1, {(width-1){1'b0}}};

    logic     clk;
    logic     arst_n;
    logic     load;
    operand_t multiplicand;
    operand_t multiplier;
    product_t product;
    logic     done;

    operand_t tab_a   [n_entries];
    operand_t tab_b   [n_entries];
    product_t tab_exp [n_entries];

    logic [15:0] lfsr;
    int          errors      = 0;
    int          runs        = 0;
    int          cycle_count = 0;

    booth_mul_top u_dut
    (
        .clk          (clk),
        .arst_n       (arst_n),
        .load         (load),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .done         (done)
    );

    always #4 clk = ~clk;   // 8 ns period

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > max_cycles)
        begin
            $display("timeout after %0d cycles, a multiply never finished", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] next_lfsr(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic draw_operand(output operand_t value);
        for (int i = 0; i < width; i++)
        begin
            lfsr     = next_lfsr(lfsr);
            value[i] = lfsr[0];         // one step per bit
        end
    endtask

    function automatic product_t signed_product(input operand_t a, input operand_t b);
        product_t wide_a;
        product_t wide_b;
        wide_a = pw'(a);    // sign extended
        wide_b = pw'(b);
        return wide_a * wide_b;
    endfunction

    task automatic value_error(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        errors++;
        $display("ERR t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
    endtask

    task automatic other_error(input string what);
        errors++;
        $display("t=%0t %s", $time, what);
    endtask

    task automatic build_table();
        operand_t dir_a [n_directed];
        operand_t dir_b [n_directed];
        operand_t ra;
        operand_t rb;
        // corners, both signs, both most negative operands
        dir_a = '{op_zero, op_zero, op_one,  op_neg1, op_max,
                  op_min,  op_min,  op_max,  op_min,  op_neg1};
        dir_b = '{op_zero, op_min,  op_neg1, op_neg1, op_max,
                  op_min,  op_max,  op_min,  op_neg1, op_min};
        for (int i = 0; i < n_directed; i++)
        begin
            tab_a[i] = dir_a[i];
            tab_b[i] = dir_b[i];
        end
        for (int i = n_directed; i < n_entries; i++)
        begin
            draw_operand(ra);
            draw_operand(rb);
            tab_a[i] = ra;
            tab_b[i] = rb;
        end
        for (int i = 0; i < n_entries; i++)
            tab_exp[i] = signed_product(tab_a[i], tab_b[i]);
    endtask

    // returns on the falling edge after the load edge
    task automatic apply_load(input operand_t a, input operand_t b);
        @(negedge clk);
        multiplicand = a;
        multiplier   = b;
        load         = 1'b1;
        @(negedge clk);
        load         = 1'b0;
    endtask

    task automatic check_result(input product_t expected);
        int latency;
        latency = 0;
        if (done !== 1'b0)
            value_error("done", 0, 32'(done));
        while (done !== 1'b1 && latency <= width + 1)
        begin
            @(negedge clk);
            latency++;
        end
        if (done !== 1'b1)
        begin
            other_error("done did not rise after the load");
        end
        else
        begin
            if (latency != width)
                value_error("done latency", width, latency);
            if (product !== expected)
                value_error("product", 32'(expected), 32'(product));
        end
    endtask

    // operands move with load low, the result must stay
    task automatic check_hold(input product_t expected);
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            if (product !== expected)
                value_error("product", 32'(expected), 32'(product));
            if (done !== 1'b1)
                value_error("done", 1, 32'(done));
            multiplicand = ~multiplicand;
            multiplier   = multiplier + op_one;
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        load         = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        lfsr         = 16'd29796;
        build_table();

        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        if (done !== 1'b0)
            value_error("done", 0, 32'(done));
        if (product !== '0)
            value_error("product", 0, 32'(product));

        for (int i = 0; i < n_entries; i++)
        begin
            apply_load(tab_a[i], tab_b[i]);
            check_result(tab_exp[i]);
            runs++;
        end

        check_hold(tab_exp[n_entries-1]);

        // second load two cycles into a run
        apply_load(op_max, op_max);
        apply_load(op_min, op_max);
        check_result(signed_product(op_min, op_max));
        runs++;

        $display("vectors %0d, errors %0d", runs, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+src
src/booth_pkg.sv
src/booth_step_if.sv
src/booth_sequencer.sv
src/booth_datapath.sv
src/booth_mul_top.sv
bench/booth_mul_sva.sv
bench/booth_mul_tb.sv

//--- src/booth_config.svh
`ifndef BOOTH_CONFIG_SVH
`define BOOTH_CONFIG_SVH

//////////////////////////////
// multiplier sizing
//////////////////////////////

// operand width, product is twice this
`define BOOTH_WIDTH 4

// step counter must reach BOOTH_WIDTH itself (idle value)
`define BOOTH_CNT_WIDTH ($clog2(`BOOTH_WIDTH) + 1)

`endif

//--- src/booth_datapath.sv
`timescale 1ns/10ps
`default_nettype none

`include "booth_config.svh"

module booth_datapath
(
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic signed [`BOOTH_WIDTH-1:0]   multiplicand,
    input  logic signed [`BOOTH_WIDTH-1:0]   multiplier,
    booth_step_if.dp                         dp,
    output logic signed [2*`BOOTH_WIDTH-1:0] product
);

    import booth_pkg::*;

    localparam int width = `BOOTH_WIDTH;

    logic signed [width-1:0] m_reg;     // multiplicand M
    prod_word_u              prod_q;    // A:Q
    logic                    q_m1_q;    // Q-1

    logic signed [width:0]   acc_ext;
    logic signed [width:0]   m_ext;
    logic signed [width:0]   sum_ext;   // one guard bit over A
    prod_word_u              added;
    prod_word_u              shifted;

    //////////////////////////////
    // add / subtract
    //////////////////////////////

    assign acc_ext = {prod_q.parts.acc[width-1], prod_q.parts.acc};
    assign m_ext   = {m_reg[width-1], m_reg};

    always_comb
    begin
        case (dp.op)
            op_add:  sum_ext = acc_ext + m_ext;
            op_sub:  sum_ext = acc_ext - m_ext;
            default: sum_ext = acc_ext;
        endcase
    end

    always_comb
    begin
        added            = prod_q;
        added.parts.acc  = sum_ext[width-1:0];
    end

    //////////////////////////////
    // arithmetic right shift
    //////////////////////////////

    // sign comes from the guard bit, so an overflow in A
    // (most negative M) still shifts in the right sign
    always_comb
    begin
        shifted                  = added;
        shifted.full             = added.full >>> 1;
        shifted.full[2*width-1]  = sum_ext[width];
    end

    //////////////////////////////
    // registers
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (dp.capture)
        begin
            m_reg <= multiplicand;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            prod_q.full <= '0;
            q_m1_q      <= 1'b0;
        end
        else if (dp.capture)
        begin
            prod_q.parts.acc  <= '0;
            prod_q.parts.mult <= multiplier;
            q_m1_q            <= 1'b0;
        end
        else if (dp.step_en)
        begin
            prod_q <= shifted;
            q_m1_q <= prod_q.parts.mult[0];   // old Q0 drops into Q-1
        end
    end

    assign dp.q0   = prod_q.parts.mult[0];
    assign dp.q_m1 = q_m1_q;

    assign product = prod_q.full;

endmodule

`default_nettype wire

//--- src/booth_mul_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "booth_config.svh"

module booth_mul_top
(
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             load,          // one cycle pulse
    input  logic signed [`BOOTH_WIDTH-1:0]   multiplicand,
    input  logic signed [`BOOTH_WIDTH-1:0]   multiplier,
    output logic signed [2*`BOOTH_WIDTH-1:0] product,       // held until next load
    output logic                             done
);

    //////////////////////////////
    // sequencer to datapath
    //////////////////////////////

    booth_step_if step_bus ();

    //////////////////////////////
    // control
    //////////////////////////////

    booth_sequencer u_seq
    (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (load),
        .step   (step_bus.seq),
        .done   (done)
    );

    //////////////////////////////
    // M, A, Q, Q-1
    //////////////////////////////

    booth_datapath u_dp
    (
        .clk          (clk),
        .arst_n       (arst_n),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .dp           (step_bus.dp),
        .product      (product)
    );

endmodule

`default_nettype wire

//--- src/booth_pkg.sv
`default_nettype none

`include "booth_config.svh"

package booth_pkg;

    //////////////////////////////
    // step action
    //////////////////////////////

    // decoded from the pair {q0, q-1}
    typedef enum logic [1:0]
    {
        op_shift = 2'b00, // 00 or 11, shift only
        op_add   = 2'b01, // 01
        op_sub   = 2'b10  // 10
    } booth_op_e;

    // counts completed steps, idles at BOOTH_WIDTH
    typedef logic [`BOOTH_CNT_WIDTH-1:0] step_cnt_t;

    //////////////////////////////
    // A:Q product word
    //////////////////////////////

    typedef struct packed
    {
        logic signed [`BOOTH_WIDTH-1:0] acc;  // A, upper half
        logic        [`BOOTH_WIDTH-1:0] mult; // Q, lower half
    } prod_fields_t;

    // full is the view used for the arithmetic shift,
    // parts is the view used by load and add/sub
    typedef union packed
    {
        logic signed [2*`BOOTH_WIDTH-1:0] full;
        prod_fields_t                     parts;
    } prod_word_u;

endpackage

`default_nettype wire

//--- src/booth_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "booth_config.svh"

module booth_sequencer
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       load,
    booth_step_if.seq  step,
    output logic       done
);

    import booth_pkg::*;

    localparam step_cnt_t n_steps   = step_cnt_t'(`BOOTH_WIDTH);
    localparam step_cnt_t last_step = step_cnt_t'(`BOOTH_WIDTH - 1);

    step_cnt_t step_cnt;
    logic      running;
    logic      last;

    //////////////////////////////
    // step control
    //////////////////////////////

    assign running = (step_cnt < n_steps);
    assign last    = (step_cnt == last_step);

    assign step.capture = load;               // datapath loads on the same edge
    assign step.step_en = running & ~load;    // a load wins over a step

    //////////////////////////////
    // booth pair decode
    //////////////////////////////

    always_comb
    begin
        case ({step.q0, step.q_m1})
            2'b10:   step.op = op_sub;   // start of a run of ones
            2'b01:   step.op = op_add;   // end of a run of ones
            default: step.op = op_shift;
        endcase
    end

    //////////////////////////////
    // step counter
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            step_cnt <= n_steps;         // idle, no steps
        end
        else if (load)
        begin
            step_cnt <= '0;              // restart, even mid run
        end
        else if (step.step_en)
        begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // done rises on the edge of the final step
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            done <= 1'b0;
        end
        else if (load)
        begin
            done <= 1'b0;
        end
        else if (step.step_en && last)
        begin
            done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/booth_step_if.sv
`timescale 1ns/10ps
`default_nettype none

interface booth_step_if;

    import booth_pkg::*;

    logic      capture; // load this cycle
    logic      step_en; // one booth step this cycle
    booth_op_e op;      // action for the step
    logic      q0;      // live Q0
    logic      q_m1;    // live Q-1

    // sequencer side, commands out and pair bits in
    modport seq
    (
        output capture,
        output step_en,
        output op,
        input  q0,
        input  q_m1
    );

    // datapath side, just follows the commands
    modport dp
    (
        input  capture,
        input  step_en,
        input  op,
        output q0,
        output q_m1
    );

endinterface

`default_nettype wire
